/* src.f */
+incdir+include
hw/ps2_pkg.sv
hw/kbd_pkg.sv
hw/ps2_rx.sv
hw/scan_decoder.sv
hw/key_filter.sv
hw/kbd_ctrl.sv
hw/ps2_keyboard.sv
dv/ps2_keyboard_chk.sv
dv/tb_ps2_keyboard.sv

/* Bender.yml */
package:
  name: ps2_keyboard

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/ps2_pkg.sv
      - hw/kbd_pkg.sv
      - hw/ps2_rx.sv
      - hw/scan_decoder.sv
      - hw/key_filter.sv
      - hw/kbd_ctrl.sv
      - hw/ps2_keyboard.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/ps2_keyboard_chk.sv
      - dv/tb_ps2_keyboard.sv

/* dv/tb_ps2_keyboard.sv */
// keyboard front end testbench: PS/2 device model, directed key tests, hold and timeout checks
`timescale 1ns/1ps
`include "kbd_cfg.svh"

module tb_ps2_keyboard;

	localparam int HALF_BIT = 20; // 40 clk cycles per PS/2 bit
	localparam int HOLD_CYCLES = 1 << `KBD_HOLD_TIMEOUT_BIT;
	// one full hold timeout plus about 50 frames with acks
	localparam int TIMEOUT_CYCLES = HOLD_CYCLES + 200000;

	logic clk;
	logic reset;
	logic key_ack;
	wire ps2_clk;
	wire ps2_dat;
	kbd_pkg::amiga_key_t key_data;
	logic key_strobe;
	logic kbd_rst;
	logic dev_clk_low; // device model pulls clock
	logic dev_dat_low;
	logic [7:0] strobes[$]; // keys seen, oldest first
	int strobe_count;
	int ack_count;
	int value_errors;
	int other_errors;
	int cycle_count;

	ps2_keyboard UUT
	(
		.clk        (clk),
		.reset      (reset),
		.key_ack    (key_ack),
		.ps2_clk    (ps2_clk),
		.ps2_dat    (ps2_dat),
		.key_data   (key_data),
		.key_strobe (key_strobe),
		.kbd_rst    (kbd_rst)
	);

	// open collector bus, device side
	pullup (ps2_clk);
	pullup (ps2_dat);
	assign ps2_clk = dev_clk_low ? 1'b0 : 1'bz;
	assign ps2_dat = dev_dat_low ? 1'b0 : 1'bz;

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// mid cycle, strobe is one cycle wide
	always @(negedge clk)
	begin
		if (!reset && key_strobe)
		begin
			strobes.push_back(key_data);
			strobe_count++;
		end
	end

	// ----------------------------------------
	// timeout
	// ----------------------------------------
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count == TIMEOUT_CYCLES)
		begin
			$display("timeout: run stopped after %0d cycles", cycle_count);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1; // inputs change just after the edge
	endtask

	// ----------------------------------------
	// PS/2 device model
	// ----------------------------------------
	task automatic send_byte(input logic [7:0] b);
		logic [10:0] frame;
		frame = {1'b1, ~^b, b, 1'b0}; // stop, odd parity, data, start
		while (ps2_clk !== 1'b1)
			wait_cycles(1); // host still holding us off
		for (int i = 0; i < 11; i++)
		begin
			dev_dat_low = ~frame[i];
			wait_cycles(HALF_BIT);
			dev_clk_low = 1'b1; // host samples on this fall
			wait_cycles(HALF_BIT);
			dev_clk_low = 1'b0;
		end
		dev_dat_low = 1'b0;
		wait_cycles(HALF_BIT); // idle high time
	endtask

	task automatic ack_key();
		key_ack = 1'b1;
		wait_cycles(1);
		key_ack = 1'b0;
		ack_count = strobe_count;
	endtask

	// one byte, acked if it made a strobe
	task automatic send_key(input logic [7:0] b);
		send_byte(b);
		if (strobe_count != ack_count)
			ack_key();
	endtask

	task automatic wait_release(input int limit, output int waited);
		waited = 0;
		while (ps2_clk !== 1'b1 && waited < limit)
		begin
			wait_cycles(1);
			waited++;
		end
	endtask

	// ----------------------------------------
	// checks
	// ----------------------------------------
	task automatic expect_key(input string name, input logic [7:0] exp);
		logic [7:0] got;
		int waited;
		waited = 0;
		while (strobes.size() == 0 && waited < 200)
		begin
			wait_cycles(1);
			waited++;
		end
		assert (strobes.size() != 0)
		else
		begin
			$display("%s: no key strobe for expected key %02h", name, exp);
			other_errors++;
		end
		if (strobes.size() != 0)
		begin
			got = strobes.pop_front();
			assert (got == exp)
			else
			begin
				$display("FAILED %s: expected %02h, actual %02h", name, exp, got);
				value_errors++;
			end
		end
	endtask

	task automatic expect_none(input string name);
		assert (strobes.size() == 0)
		else
		begin
			$display("%s: %0d key strobes arrived that should not have", name, strobes.size());
			other_errors++;
		end
		strobes.delete();
	endtask

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
		assert (got == exp)
		else
		begin
			$display("FAILED %s: expected %02h, actual %02h", name, exp, got);
			value_errors++;
		end
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic test_translate();
		send_key(8'h1c);
		expect_key("translate", 8'h20); // a down
		send_key(8'hf0);
		send_key(8'h1c);
		expect_key("translate", 8'ha0); // a up
		send_key(8'h16);
		expect_key("translate", 8'h01);
		send_key(8'hf0);
		send_key(8'h16);
		expect_key("translate", 8'h81);
		send_key(8'h29);
		expect_key("translate", 8'h40); // space
		send_key(8'hf0);
		send_key(8'h29);
		expect_key("translate", 8'hc0);
		expect_none("translate");
	endtask

	task automatic test_extended();
		send_key(8'he0);
		send_key(8'h75);
		expect_key("extended", 8'h4c); // arrow up
		send_key(8'he0);
		send_key(8'hf0);
		send_key(8'h75);
		expect_key("extended", 8'hcc);
		send_key(8'he0);
		send_key(8'h11);
		expect_key("extended", 8'h65); // right alt
		send_key(8'he0);
		send_key(8'hf0);
		send_key(8'h11);
		expect_key("extended", 8'he5);
		send_key(8'h0f); // unmapped
		send_key(8'he0);
		send_key(8'hfa); // ack keeps the prefix
		send_key(8'h0f); // E0 0F unmapped too, clears prefix
		send_key(8'hf0);
		send_key(8'h0f);
		expect_none("extended");
	endtask

	task automatic test_typematic();
		repeat (3)
			send_key(8'h1c); // keyboard repeat
		expect_key("typematic", 8'h20);
		expect_none("typematic");
		send_key(8'hf0);
		send_key(8'h1c);
		expect_key("typematic", 8'ha0);
		send_key(8'h1c);
		expect_key("typematic", 8'h20); // fresh press after break
		send_key(8'hf0);
		send_key(8'h1c);
		expect_key("typematic", 8'ha0);
		expect_none("typematic");
	endtask

	task automatic test_caps();
		repeat (2)
		begin
			send_key(8'h58);
			send_key(8'hf0);
			send_key(8'h58);
		end
		expect_key("caps", 8'h62); // latched on
		expect_key("caps", 8'he2); // released on second press cycle
		expect_none("caps");
	endtask

	task automatic test_reset_combo();
		send_key(8'h14); // ctrl
		check_value("reset_combo", 8'h00, {7'b0, kbd_rst});
		send_key(8'h11); // left alt
		check_value("reset_combo", 8'h00, {7'b0, kbd_rst});
		send_key(8'he0);
		send_key(8'h11); // right alt, all three
		check_value("reset_combo", 8'h01, {7'b0, kbd_rst});
		send_key(8'hf0);
		send_key(8'h11);
		check_value("reset_combo", 8'h00, {7'b0, kbd_rst});
		send_key(8'hf0);
		send_key(8'h14);
		send_key(8'h11); // both alts, no ctrl
		check_value("reset_combo", 8'h00, {7'b0, kbd_rst});
		send_key(8'he0);
		send_key(8'hf0);
		send_key(8'h11);
		send_key(8'hf0);
		send_key(8'h11);
		check_value("reset_combo", 8'h00, {7'b0, kbd_rst});
		strobes.delete(); // key values covered elsewhere
	endtask

	task automatic test_hold();
		int waited;
		send_byte(8'h1c);
		expect_key("hold", 8'h20);
		wait_cycles(1000); // no ack yet
		assert (ps2_clk === 1'b0)
		else
		begin
			$display("hold: ps2_clk released before key_ack");
			other_errors++;
		end
		ack_key();
		wait_release(20, waited);
		assert (ps2_clk === 1'b1)
		else
		begin
			$display("hold: ps2_clk still low %0d cycles after key_ack", waited);
			other_errors++;
		end
		send_byte(8'hf0);
		send_byte(8'h1c);
		expect_key("hold", 8'ha0);
		wait_release(HOLD_CYCLES + 100, waited); // no ack this time
		assert (ps2_clk === 1'b1 && waited >= HOLD_CYCLES - 100)
		else
		begin
			$display("hold: timeout release wrong, clock %b after %0d cycles", ps2_clk, waited);
			other_errors++;
		end
		ack_count = strobe_count; // timed out, nothing to ack
		send_key(8'h29);
		expect_key("hold", 8'h40);
		send_key(8'hf0);
		send_key(8'h29);
		expect_key("hold", 8'hc0);
		expect_none("hold");
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		reset = 1'b1;
		key_ack = 1'b0;
		dev_clk_low = 1'b0;
		dev_dat_low = 1'b0;
		strobe_count = 0;
		ack_count = 0;
		value_errors = 0;
		other_errors = 0;
		cycle_count = 0;
		wait_cycles(8);
		reset = 1'b0;
		wait_cycles(10);
		test_translate();
		test_extended();
		test_typematic();
		test_caps();
		test_reset_combo();
		test_hold();
		$display("error count: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* dv/ps2_keyboard_chk.sv */
// keyboard front end checker: key strobe and PS/2 clock inhibit rules
`timescale 1ns/1ps

module ps2_keyboard_chk
(
	input logic                clk,
	input logic                reset,
	input logic                key_strobe,
	input logic                clk_inhibit,
	input kbd_pkg::kbd_state_e state // controller state
);

	// strobe path is clear from the second reset edge on
	no_strobe_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !key_strobe)
		else $error("key strobe raised during reset");

	// hold only ever entered right after a key strobe
	inhibit_after_strobe: assert property (@(posedge clk) disable iff (reset)
		$rose(clk_inhibit) |-> $past(key_strobe))
		else $error("ps2 clock inhibited without a preceding key strobe");

	// keyboard is off, nothing may arrive
	no_strobe_in_hold: assert property (@(posedge clk) disable iff (reset)
		state == kbd_pkg::KBD_HOLD |-> !key_strobe)
		else $error("key strobe raised while the keyboard is held off");

endmodule

bind ps2_keyboard ps2_keyboard_chk u_chk
(
	.clk         (clk),
	.reset       (reset),
	.key_strobe  (key_strobe),
	.clk_inhibit (clk_inhibit),
	.state       (u_ctrl.state)
);

/* hw/ps2_keyboard.sv */
// PS/2 keyboard front end top: receiver, decoder, key filter and hold controller
`timescale 1ns/1ps

module ps2_keyboard
(
	input  logic                clk,
	input  logic                reset,
	input  logic                key_ack,
	inout  wire                 ps2_clk,
	inout  wire                 ps2_dat,
	output kbd_pkg::amiga_key_t key_data,   // valid with key_strobe
	output logic                key_strobe,
	output logic                kbd_rst     // ctrl + both alts held
);

	ps2_pkg::ps2_byte_t rx_byte;
	logic rx_ready;
	kbd_pkg::decoded_key_t decoded;
	logic clk_inhibit;

	// ----------------------------------------
	// receive path
	// ----------------------------------------
	ps2_rx u_rx
	(
		.clk         (clk),
		.reset       (reset),
		.ps2_clk     (ps2_clk),
		.ps2_dat     (ps2_dat),
		.clk_inhibit (clk_inhibit),
		.rx_byte     (rx_byte),
		.rx_ready    (rx_ready)
	);

	scan_decoder u_decoder
	(
		.clk      (clk),
		.reset    (reset),
		.rx_ready (rx_ready),
		.rx_byte  (rx_byte),
		.decoded  (decoded)
	);

	key_filter u_filter
	(
		.clk        (clk),
		.reset      (reset),
		.decoded    (decoded),
		.key_strobe (key_strobe),
		.kbd_rst    (kbd_rst)
	);

	// hold keyboard off until host ack
	kbd_ctrl u_ctrl
	(
		.clk         (clk),
		.reset       (reset),
		.key_strobe  (key_strobe),
		.key_ack     (key_ack),
		.clk_inhibit (clk_inhibit)
	);

	assign key_data = decoded.key; // holds until the next mapped key

endmodule

/* hw/kbd_ctrl.sv */
// keyboard controller: holds the PS/2 clock low after each key until ack or timeout
`timescale 1ns/1ps
`include "kbd_cfg.svh"

module kbd_ctrl
(
	input  logic clk,
	input  logic reset,
	input  logic key_strobe, // key passed to host
	input  logic key_ack,    // host took it
	output logic clk_inhibit
);

	kbd_pkg::kbd_state_e state;
	kbd_pkg::kbd_state_e state_next;
	logic [`KBD_HOLD_TIMER_BITS-1:0] hold_timer;
	logic timeout;

	// ----------------------------------------
	// hold timer
	// ----------------------------------------

	// stops counting once the timeout bit is set
	assign timeout = hold_timer[`KBD_HOLD_TIMEOUT_BIT];

	always_ff @(posedge clk)
	begin
		if (reset || state == kbd_pkg::KBD_WAIT)
			hold_timer <= '0; // starts at zero on hold entry
		else if (!timeout)
			hold_timer <= hold_timer + 1'b1;
	end

	// ----------------------------------------
	// state machine
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= kbd_pkg::KBD_WAIT;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			kbd_pkg::KBD_WAIT:
				if (key_strobe)
					state_next = kbd_pkg::KBD_HOLD; // stop keyboard sending
			kbd_pkg::KBD_HOLD:
				if (key_ack || timeout)
					state_next = kbd_pkg::KBD_WAIT; // host done or gave up
		endcase
	end

	// clock held low for the whole hold, this is the back-pressure
	assign clk_inhibit = state == kbd_pkg::KBD_HOLD;

endmodule

/* hw/key_filter.sv */
// key filter: typematic repeat removal, latching caps lock, key strobe, reset combination
`timescale 1ns/1ps

module key_filter
(
	input  logic                  clk,
	input  logic                  reset,
	input  kbd_pkg::decoded_key_t decoded,
	output logic                  key_strobe,
	output logic                  kbd_rst
);

	kbd_pkg::amiga_key_t last_key; // last downstroke seen
	logic key_equal;
	logic duplicate;
	logic caps_on; // emulated caps lock state
	logic ctrl_up;
	logic lalt_up;
	logic ralt_up;

	// ----------------------------------------
	// typematic filter
	// ----------------------------------------

	// keyboard repeats the last make code, amiga does not
	assign key_equal = decoded.key.code == last_key.code;
	assign duplicate = key_equal && (decoded.key.up == last_key.up);

	always_ff @(posedge clk)
	begin
		if (reset)
			last_key <= '{up: 1'b1, code: 7'h00}; // nothing held
		else if (decoded.valid && !decoded.key.up)
			last_key <= decoded.key;
		else if (decoded.valid && decoded.key.up && key_equal)
			last_key <= decoded.key; // matching break clears to up form
	end

	// ----------------------------------------
	// caps lock emulation
	// ----------------------------------------

	// toggles on each fresh press, amiga keeps caps in the keyboard
	always_ff @(posedge clk)
	begin
		if (reset)
			caps_on <= 1'b0;
		else if (decoded.valid && !decoded.key.up && decoded.flags.caps && !duplicate)
			caps_on <= ~caps_on;
	end

	// caps events swallowed while latched on
	assign key_strobe = decoded.valid && !duplicate && !(caps_on && decoded.flags.caps);

	// ----------------------------------------
	// ctrl + left alt + right alt
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ctrl_up <= 1'b1;
			lalt_up <= 1'b1;
			ralt_up <= 1'b1;
		end
		else if (decoded.valid)
		begin
			if (decoded.flags.ctrl)
				ctrl_up <= decoded.key.up;
			if (decoded.flags.left_alt)
				lalt_up <= decoded.key.up;
			if (decoded.flags.right_alt)
				ralt_up <= decoded.key.up;
		end
	end

	assign kbd_rst = ~(ctrl_up | lalt_up | ralt_up); // all three down

endmodule

/* hw/scan_decoder.sv */
// scan code decoder: E0/F0 prefix tracking and registered PS/2 to Amiga key table
`timescale 1ns/1ps

module scan_decoder
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  rx_ready,
	input  ps2_pkg::ps2_byte_t    rx_byte,
	output kbd_pkg::decoded_key_t decoded
);

	// one table entry
	typedef struct packed
	{
		logic                hit;   // real amiga key
		kbd_pkg::key_flags_t flags;
		logic [6:0]          code;
	} rom_entry_t;

	// flag patterns, order ctrl / left alt / right alt / caps
	localparam kbd_pkg::key_flags_t FL_NONE = 4'b0000;
	localparam kbd_pkg::key_flags_t FL_CTRL = 4'b1000;
	localparam kbd_pkg::key_flags_t FL_LALT = 4'b0100;
	localparam kbd_pkg::key_flags_t FL_RALT = 4'b0010;
	localparam kbd_pkg::key_flags_t FL_CAPS = 4'b0001;

	logic extended; // E0 seen
	logic upstroke; // F0 seen
	rom_entry_t rom;

	// ----------------------------------------
	// key table, {extended, scan code}
	// ----------------------------------------
	always_comb
	begin
		case ({extended, rx_byte})
			9'h01c: rom = {1'b1, FL_NONE, 7'h20}; // a
			9'h032: rom = {1'b1, FL_NONE, 7'h35}; // b
			9'h021: rom = {1'b1, FL_NONE, 7'h33}; // c
			9'h023: rom = {1'b1, FL_NONE, 7'h22}; // d
			9'h024: rom = {1'b1, FL_NONE, 7'h12}; // e
			9'h02b: rom = {1'b1, FL_NONE, 7'h23}; // f
			9'h034: rom = {1'b1, FL_NONE, 7'h24}; // g
			9'h033: rom = {1'b1, FL_NONE, 7'h25}; // h
			9'h043: rom = {1'b1, FL_NONE, 7'h17}; // i
			9'h03b: rom = {1'b1, FL_NONE, 7'h26}; // j
			9'h042: rom = {1'b1, FL_NONE, 7'h27}; // k
			9'h04b: rom = {1'b1, FL_NONE, 7'h28}; // l
			9'h03a: rom = {1'b1, FL_NONE, 7'h37}; // m
			9'h031: rom = {1'b1, FL_NONE, 7'h36}; // n
			9'h044: rom = {1'b1, FL_NONE, 7'h18}; // o
			9'h04d: rom = {1'b1, FL_NONE, 7'h19}; // p
			9'h015: rom = {1'b1, FL_NONE, 7'h10}; // q
			9'h02d: rom = {1'b1, FL_NONE, 7'h13}; // r
			9'h01b: rom = {1'b1, FL_NONE, 7'h21}; // s
			9'h02c: rom = {1'b1, FL_NONE, 7'h14}; // t
			9'h03c: rom = {1'b1, FL_NONE, 7'h16}; // u
			9'h02a: rom = {1'b1, FL_NONE, 7'h34}; // v
			9'h01d: rom = {1'b1, FL_NONE, 7'h11}; // w
			9'h022: rom = {1'b1, FL_NONE, 7'h32}; // x
			9'h035: rom = {1'b1, FL_NONE, 7'h15}; // y
			9'h01a: rom = {1'b1, FL_NONE, 7'h31}; // z
			9'h045: rom = {1'b1, FL_NONE, 7'h0a}; // 0
			9'h016: rom = {1'b1, FL_NONE, 7'h01}; // 1
			9'h01e: rom = {1'b1, FL_NONE, 7'h02}; // 2
			9'h026: rom = {1'b1, FL_NONE, 7'h03}; // 3
			9'h025: rom = {1'b1, FL_NONE, 7'h04}; // 4
			9'h02e: rom = {1'b1, FL_NONE, 7'h05}; // 5
			9'h036: rom = {1'b1, FL_NONE, 7'h06}; // 6
			9'h03d: rom = {1'b1, FL_NONE, 7'h07}; // 7
			9'h03e: rom = {1'b1, FL_NONE, 7'h08}; // 8
			9'h046: rom = {1'b1, FL_NONE, 7'h09}; // 9
			9'h029: rom = {1'b1, FL_NONE, 7'h40}; // space
			9'h05a: rom = {1'b1, FL_NONE, 7'h44}; // enter
			9'h076: rom = {1'b1, FL_NONE, 7'h45}; // escape
			9'h066: rom = {1'b1, FL_NONE, 7'h41}; // backspace
			9'h012: rom = {1'b1, FL_NONE, 7'h60}; // left shift
			9'h059: rom = {1'b1, FL_NONE, 7'h61}; // right shift
			9'h014: rom = {1'b1, FL_CTRL, 7'h63}; // ctrl
			9'h011: rom = {1'b1, FL_LALT, 7'h64}; // left alt
			9'h111: rom = {1'b1, FL_RALT, 7'h65}; // right alt
			9'h058: rom = {1'b1, FL_CAPS, 7'h62}; // caps lock
			9'h175: rom = {1'b1, FL_NONE, 7'h4c}; // arrow up
			9'h172: rom = {1'b1, FL_NONE, 7'h4d}; // arrow down
			9'h174: rom = {1'b1, FL_NONE, 7'h4e}; // arrow right
			9'h16b: rom = {1'b1, FL_NONE, 7'h4f}; // arrow left
			default: rom = {1'b0, FL_NONE, 7'h00}; // prefixes, ack, unmapped
		endcase
	end

	// ----------------------------------------
	// output register and prefix flags
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			extended <= 1'b0;
			upstroke <= 1'b0;
			decoded.valid <= 1'b0;
		end
		else
		begin
			decoded.valid <= rx_ready & rom.hit; // pulse for real keys only
			if (rx_ready && rom.hit)
			begin
				decoded.key.up <= upstroke; // prefix seen before this code
				decoded.key.code <= rom.code;
				decoded.flags <= rom.flags;
			end
			if (rx_ready)
			begin
				case (rx_byte)
					ps2_pkg::PS2_EXTENDED: extended <= 1'b1;
					ps2_pkg::PS2_RELEASE: upstroke <= 1'b1;
					ps2_pkg::PS2_ACK: ; // flags kept
					default:
					begin
						// any other code ends the sequence
						extended <= 1'b0;
						upstroke <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

/* hw/ps2_rx.sv */
// PS/2 receiver: line synchronizers, clock edge detect, frame shifter, open-collector drivers
`timescale 1ns/1ps
`include "kbd_cfg.svh"

module ps2_rx
(
	input  logic               clk,
	input  logic               reset,
	inout  wire                ps2_clk,
	inout  wire                ps2_dat,
	input  logic               clk_inhibit, // hold keyboard off
	output ps2_pkg::ps2_byte_t rx_byte,
	output logic               rx_ready     // one cycle per frame
);

	logic [1:0] clk_sync; // [0] first stage
	logic [1:0] dat_sync;
	logic clk_fall;
	ps2_pkg::ps2_frame_t frame;

	// ----------------------------------------
	// open collector pads
	// ----------------------------------------

	// only ever pull low or let go, pull-ups are external
	assign ps2_clk = clk_inhibit ? 1'b0 : 1'bz;
	assign ps2_dat = 1'bz; // receive only

	// both lines are asynchronous to clk
	always_ff @(posedge clk)
	begin
		clk_sync <= {clk_sync[0], ps2_clk};
		dat_sync <= {dat_sync[0], ps2_dat};
	end

	assign clk_fall = clk_sync[1] & ~clk_sync[0]; // high then low

	// ----------------------------------------
	// frame shifter
	// ----------------------------------------

	// preset to ones, bits enter at the top
	// start bit (0) reaching bit 0 marks a full frame
	// our own inhibit edge shifts in an idle 1 and changes nothing
	always_ff @(posedge clk)
	begin
		if (reset || rx_ready)
			frame <= {`KBD_FRAME_BITS{1'b1}};
		else if (clk_fall)
			frame <= {dat_sync[1], frame[`KBD_FRAME_BITS-1:1]};
	end

	assign rx_ready = ~frame[0];
	assign rx_byte = frame[8:1]; // parity and stop not checked

endmodule

/* hw/kbd_pkg.sv */
// Amiga side types: raw key code, modifier flags, decoded key, controller states
package kbd_pkg;

	// ----------------------------------------
	// key codes
	// ----------------------------------------

	// amiga raw key, up bit on top as on the real keyboard
	typedef struct packed
	{
		logic       up;   // 1 = key released
		logic [6:0] code; // amiga raw code
	} amiga_key_t;

	// keys with special handling further down
	typedef struct packed
	{
		logic ctrl;      // reset combination
		logic left_alt;  // reset combination
		logic right_alt; // reset combination
		logic caps;      // latching caps lock
	} key_flags_t;

	// decoder output, valid is a single cycle pulse
	typedef struct packed
	{
		logic       valid;
		amiga_key_t key;
		key_flags_t flags;
	} decoded_key_t;

	// ----------------------------------------
	// controller
	// ----------------------------------------

	typedef enum logic
	{
		KBD_WAIT = 1'b0, // keyboard free to send
		KBD_HOLD = 1'b1  // clock pulled low until host ack
	} kbd_state_e;

endpackage

/* hw/ps2_pkg.sv */
// PS/2 side types: protocol codes and raw frame/byte containers
`include "kbd_cfg.svh"

package ps2_pkg;

	// ----------------------------------------
	// raw data
	// ----------------------------------------

	// one scan code byte as sent by the keyboard
	typedef logic [7:0] ps2_byte_t;

	// whole frame as shifted in, lsb first
	// bit 0 start, 8:1 data, 9 parity, 10 stop
	typedef logic [`KBD_FRAME_BITS-1:0] ps2_frame_t;

	// ----------------------------------------
	// protocol codes
	// ----------------------------------------

	// bytes that carry no key themselves
	typedef enum logic [7:0]
	{
		PS2_EXTENDED = 8'hE0, // next code from extended set
		PS2_RELEASE  = 8'hF0, // next code is a break
		PS2_ACK      = 8'hFA  // keyboard ack, ignored
	} ps2_code_e;

endpackage

/* include/kbd_cfg.svh */
// keyboard front end constants: PS/2 frame length and hold timer sizing
`ifndef KBD_CFG_SVH
`define KBD_CFG_SVH

// ----------------------------------------
// PS/2 frame
// ----------------------------------------

// start + 8 data + parity + stop
`define KBD_FRAME_BITS 11

// ----------------------------------------
// hold timer
// ----------------------------------------

// free running counter while the keyboard is held off
`define KBD_HOLD_TIMER_BITS 20

// hold ends when this bit sets, 2^19 clk cycles
// roughly 74 ms at a 7.09 MHz bus clock
`define KBD_HOLD_TIMEOUT_BIT 19

`endif
